// ==== design/ps2_defines.svh ====
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// Identical ps2c samples needed before the filtered clock changes
`define PS2_FILTER_LEN 8

// Host holds ps2c low this many system cycles before a request to send
`define PS2_INHIBIT_CYCLES 16'd5000

// Receive FIFO entries, power of two
`define PS2_FIFO_DEPTH 8

// Wishbone word address and data widths
`define PS2_WB_ADR_W 2
`define PS2_WB_DAT_W 8

`endif

// ==== design/ps2_pkg.sv ====
package ps2_pkg;

   typedef enum logic [1:0] {
      rx_idle,
      rx_dps,
      rx_load
   } rx_state_t;

   typedef enum logic [2:0] {
      tx_idle,
      tx_inhibit,
      tx_request,
      tx_shift,
      tx_release,
      tx_ack
   } tx_state_t;

   typedef enum logic [1:0] {
      reg_data   = 2'd0,
      reg_status = 2'd1,
      reg_ctrl   = 2'd2
   } ps2_reg_e;

   typedef struct packed {
      logic [7:0] data;
      logic       parity_err;
   } ps2_frame_t;

   // rx_valid ends up in bit 0 of the status register
   typedef struct packed {
      logic tx_noack;
      logic overflow;
      logic parity_err;
      logic tx_busy;
      logic fifo_full;
      logic rx_valid;
   } ps2_status_t;

endpackage

// ==== design/ps2_clk_filter.sv ====
`include "ps2_defines.svh"

module ps2_clk_filter
(
   input  logic clk,
   input  logic reset,
   input  logic ps2c,
   output logic fall_edge
);
   logic [1:0]                 sync_reg;
   logic [`PS2_FILTER_LEN-1:0] filter_reg;
   logic                       f_ps2c_reg;
   logic                       f_ps2c_next;

   // Idle line is high, so everything comes out of reset as ones
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         sync_reg   <= '1;
         filter_reg <= '1;
         f_ps2c_reg <= 1'b1;
      end
      else
      begin
         sync_reg   <= {sync_reg[0], ps2c};
         filter_reg <= {sync_reg[1], filter_reg[`PS2_FILTER_LEN-1:1]};
         f_ps2c_reg <= f_ps2c_next;
      end
   end

   assign f_ps2c_next = (&filter_reg)  ? 1'b1 :
                        (~|filter_reg) ? 1'b0 :
                        f_ps2c_reg;                 // Hold until samples agree
   assign fall_edge   = f_ps2c_reg & ~f_ps2c_next;
endmodule

// ==== design/ps2_rx.sv ====
module ps2_rx import ps2_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ps2d,
   input  logic       fall_edge,
   input  logic       rx_en,
   output logic       rx_done_tick,
   output ps2_frame_t frame
);
   rx_state_t   state_reg;
   rx_state_t   state_next;
   logic [3:0]  n_reg;
   logic [3:0]  n_next;
   logic [10:0] b_reg;
   logic        shift_en;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state_reg <= rx_idle;
         n_reg     <= 4'd0;
      end
      else
      begin
         state_reg <= state_next;
         n_reg     <= n_next;
      end
   end

   // Bits arrive LSB first, start bit ends up in b_reg[0]
   always_ff @(posedge clk)
   begin
      if (shift_en)
         b_reg <= {ps2d, b_reg[10:1]};
   end

   always_comb
   begin
      state_next   = state_reg;
      n_next       = n_reg;
      shift_en     = 1'b0;
      rx_done_tick = 1'b0;
      case (state_reg)
         rx_idle:
            if (fall_edge && rx_en)
            begin
               shift_en   = 1'b1;
               n_next     = 4'd9;    // Ten more edges to go
               state_next = rx_dps;
            end
         rx_dps:
            if (fall_edge)
            begin
               shift_en = 1'b1;
               if (n_reg == 4'd0)
                  state_next = rx_load;
               else
                  n_next = n_reg - 4'd1;
            end
         rx_load:
         begin
            rx_done_tick = 1'b1;
            state_next   = rx_idle;
         end
         default:
            state_next = rx_idle;
      endcase
   end

   assign frame.data       = b_reg[8:1];
   assign frame.parity_err = ~^b_reg[9:1];   // Data plus parity bit must be odd
endmodule

// ==== design/ps2_tx.sv ====
`include "ps2_defines.svh"

module ps2_tx import ps2_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ps2d,
   input  logic       fall_edge,
   input  logic       tx_start,
   input  logic [7:0] tx_data,
   output logic       tx_busy,
   output logic       tx_done,
   output logic       tx_acked,
   output logic       ps2c_low,
   output logic       ps2d_low
);
   tx_state_t   state_reg;
   logic [15:0] cnt_reg;
   logic [3:0]  n_reg;
   logic [9:0]  sh_reg;   // Stop, parity, data

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state_reg <= tx_idle;
         cnt_reg   <= 16'd0;
         n_reg     <= 4'd0;
         ps2c_low  <= 1'b0;
         ps2d_low  <= 1'b0;
         tx_acked  <= 1'b0;
      end
      else
      begin
         case (state_reg)
            tx_idle:
               if (tx_start)
               begin
                  cnt_reg   <= 16'd0;
                  ps2c_low  <= 1'b1;      // Inhibit the device
                  state_reg <= tx_inhibit;
               end
            tx_inhibit:
               if (cnt_reg == `PS2_INHIBIT_CYCLES - 16'd1)
               begin
                  ps2d_low  <= 1'b1;      // Start bit
                  state_reg <= tx_request;
               end
               else
                  cnt_reg <= cnt_reg + 16'd1;
            tx_request:
            begin
               ps2c_low <= 1'b0;
               // Device reads the start bit during its first clock
               if (fall_edge)
               begin
                  n_reg     <= 4'd9;
                  state_reg <= tx_shift;
               end
            end
            tx_shift:
               if (fall_edge)
               begin
                  ps2d_low <= ~sh_reg[0];
                  if (n_reg == 4'd0)
                     state_reg <= tx_release;   // Stop bit now on the line
                  else
                     n_reg <= n_reg - 4'd1;
               end
            tx_release:
               // Device pulls data low for the ack clock
               if (fall_edge)
               begin
                  tx_acked  <= ~ps2d;
                  state_reg <= tx_ack;
               end
            tx_ack:
               state_reg <= tx_idle;
            default:
               state_reg <= tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_reg == tx_idle && tx_start)
         sh_reg <= {1'b1, ~^tx_data, tx_data};
      else if (state_reg == tx_shift && fall_edge)
         sh_reg <= {1'b1, sh_reg[9:1]};
   end

   assign tx_busy = (state_reg != tx_idle);
   assign tx_done = (state_reg == tx_ack);
endmodule

// ==== design/ps2_rx_fifo.sv ====
`include "ps2_defines.svh"

module ps2_rx_fifo import ps2_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       push,
   input  ps2_frame_t din,
   input  logic       pop,
   output ps2_frame_t head,
   output logic       empty,
   output logic       full,
   output logic       overflow
);
   localparam int AW = $clog2(`PS2_FIFO_DEPTH);

   ps2_frame_t    mem [`PS2_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_push;
   logic          do_pop;

   assign empty    = (count == '0);
   assign full     = (count == (AW+1)'(`PS2_FIFO_DEPTH));
   assign do_push  = push & ~full;
   assign do_pop   = pop & ~empty;
   assign overflow = push & full;   // Frame is lost
   assign head     = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end
endmodule

// ==== design/ps2_wb_regs.sv ====
`include "ps2_defines.svh"

module ps2_wb_regs import ps2_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cyc,
   input  logic                     stb,
   input  logic                     we,
   input  logic [`PS2_WB_ADR_W-1:0] adr,
   input  logic [`PS2_WB_DAT_W-1:0] dat_w,
   output logic [`PS2_WB_DAT_W-1:0] dat_r,
   output logic                     ack,
   input  ps2_frame_t               head,
   input  logic                     empty,
   input  logic                     full,
   input  logic                     overflow,
   output logic                     pop,
   input  logic                     tx_busy,
   input  logic                     tx_done,
   input  logic                     tx_acked,
   output logic                     tx_start,
   output logic [7:0]               tx_data,
   output logic                     rx_enable
);
   ps2_reg_e    reg_sel;
   ps2_status_t status;
   ps2_status_t clr;
   logic        rd_ack;
   logic        wr_ack;
   logic        parity_err_reg;
   logic        overflow_reg;
   logic        tx_noack_reg;

   assign reg_sel = ps2_reg_e'(adr);
   assign rd_ack  = ack & ~we;
   assign wr_ack  = ack & we;

   // One ack per request, then one idle cycle
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         ack <= 1'b0;
      else
         ack <= cyc & stb & ~ack;
   end

   assign pop      = rd_ack && (reg_sel == reg_data) && !empty;
   assign tx_start = wr_ack && (reg_sel == reg_data) && !tx_busy;
   assign tx_data  = dat_w[7:0];

   // Write one to clear
   assign clr = (wr_ack && reg_sel == reg_status) ?
                ps2_status_t'(dat_w[$bits(ps2_status_t)-1:0]) : '0;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         parity_err_reg <= 1'b0;
         overflow_reg   <= 1'b0;
         tx_noack_reg   <= 1'b0;
         rx_enable      <= 1'b0;
      end
      else
      begin
         parity_err_reg <= (parity_err_reg & ~clr.parity_err) | (pop & head.parity_err);
         overflow_reg   <= (overflow_reg & ~clr.overflow) | overflow;
         tx_noack_reg   <= (tx_noack_reg & ~clr.tx_noack) | (tx_done & ~tx_acked);
         if (wr_ack && reg_sel == reg_ctrl)
            rx_enable <= dat_w[0];
      end
   end

   assign status.rx_valid   = ~empty;
   assign status.fifo_full  = full;
   assign status.tx_busy    = tx_busy;
   assign status.parity_err = parity_err_reg;
   assign status.overflow   = overflow_reg;
   assign status.tx_noack   = tx_noack_reg;

   always_comb
   begin
      dat_r = '0;
      case (reg_sel)
         reg_data:
            if (!empty)
               dat_r[7:0] = head.data;
         reg_status:
            dat_r[$bits(ps2_status_t)-1:0] = status;
         reg_ctrl:
            dat_r[0] = rx_enable;
         default:
            dat_r = '0;
      endcase
   end
endmodule

// ==== design/ps2_host.sv ====
`include "ps2_defines.svh"

module ps2_host import ps2_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cyc,
   input  logic                     stb,
   input  logic                     we,
   input  logic [`PS2_WB_ADR_W-1:0] adr,
   input  logic [`PS2_WB_DAT_W-1:0] dat_w,
   output logic [`PS2_WB_DAT_W-1:0] dat_r,
   output logic                     ack,
   inout  wire                      ps2c,
   inout  wire                      ps2d
);
   logic       fall_edge;
   logic       rx_done_tick;
   logic       rx_en;
   logic       rx_enable;
   ps2_frame_t rx_frame;
   ps2_frame_t fifo_head;
   logic       fifo_empty;
   logic       fifo_full;
   logic       fifo_overflow;
   logic       fifo_pop;
   logic       tx_start;
   logic [7:0] tx_data;
   logic       tx_busy;
   logic       tx_done;
   logic       tx_acked;
   logic       ps2c_low;
   logic       ps2d_low;

   // Open drain, pulled up outside
   assign ps2c = ps2c_low ? 1'b0 : 1'bz;
   assign ps2d = ps2d_low ? 1'b0 : 1'bz;

   assign rx_en = rx_enable & ~tx_busy;   // Don't receive our own frames

   ps2_clk_filter ps2_clk_filter_i (
      .clk       (clk),
      .reset     (reset),
      .ps2c      (ps2c),
      .fall_edge (fall_edge)
   );

   ps2_rx ps2_rx_i (
      .clk          (clk),
      .reset        (reset),
      .ps2d         (ps2d),
      .fall_edge    (fall_edge),
      .rx_en        (rx_en),
      .rx_done_tick (rx_done_tick),
      .frame        (rx_frame)
   );

   ps2_tx ps2_tx_i (
      .clk       (clk),
      .reset     (reset),
      .ps2d      (ps2d),
      .fall_edge (fall_edge),
      .tx_start  (tx_start),
      .tx_data   (tx_data),
      .tx_busy   (tx_busy),
      .tx_done   (tx_done),
      .tx_acked  (tx_acked),
      .ps2c_low  (ps2c_low),
      .ps2d_low  (ps2d_low)
   );

   ps2_rx_fifo ps2_rx_fifo_i (
      .clk      (clk),
      .reset    (reset),
      .push     (rx_done_tick),
      .din      (rx_frame),
      .pop      (fifo_pop),
      .head     (fifo_head),
      .empty    (fifo_empty),
      .full     (fifo_full),
      .overflow (fifo_overflow)
   );

   ps2_wb_regs ps2_wb_regs_i (
      .clk       (clk),
      .reset     (reset),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .head      (fifo_head),
      .empty     (fifo_empty),
      .full      (fifo_full),
      .overflow  (fifo_overflow),
      .pop       (fifo_pop),
      .tx_busy   (tx_busy),
      .tx_done   (tx_done),
      .tx_acked  (tx_acked),
      .tx_start  (tx_start),
      .tx_data   (tx_data),
      .rx_enable (rx_enable)
   );
endmodule

// ==== sim/ps2_host_tb.sv ====
`include "ps2_defines.svh"

module ps2_host_tb import ps2_pkg::*; ();

   typedef enum logic [1:0] {
      k_rx,
      k_fill,
      k_tx,
      k_off
   } kind_e;

   typedef struct packed {
      kind_e      kind;
      logic [7:0] data;
      logic       bad;   // Parity inverted on the wire
      logic       ack;   // Device acks a host frame
   } entry_t;

   localparam int half_bit = 40;   // Device clock half period

   logic                     clk;
   logic                     reset;
   logic                     cyc;
   logic                     stb;
   logic                     we;
   logic [`PS2_WB_ADR_W-1:0] adr;
   logic [`PS2_WB_DAT_W-1:0] dat_w;
   logic [`PS2_WB_DAT_W-1:0] dat_r;
   logic                     ack;
   tri1                      ps2c;
   tri1                      ps2d;
   logic                     dev_c_low;
   logic                     dev_d_low;

   entry_t     table_q[$];
   logic [7:0] fill_q[$];
   integer     seed;
   int         cycles;
   int         limit;
   int         n_checks;
   int         n_errors;
   int         group_base;
   int         test_no;

   // Device side of the open-drain lines
   assign ps2c = dev_c_low ? 1'b0 : 1'bz;
   assign ps2d = dev_d_low ? 1'b0 : 1'bz;

   ps2_host ps2_host_i (
      .clk   (clk),
      .reset (reset),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .ps2c  (ps2c),
      .ps2d  (ps2d)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > limit)
      begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic wb_read(input ps2_reg_e a, output logic [7:0] d);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= a;
      do
      begin
         @(posedge clk);
      end
      while (ack !== 1'b1);
      d = dat_r;
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic wb_write(input ps2_reg_e a, input logic [7:0] d);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= a;
      dat_w <= d;
      do
      begin
         @(posedge clk);
      end
      while (ack !== 1'b1);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic read_status(output ps2_status_t st);
      logic [7:0] d;
      wb_read(reg_status, d);
      st = ps2_status_t'(d[$bits(ps2_status_t)-1:0]);
   endtask

   task automatic clear_sticky(input ps2_status_t bits);
      wb_write(reg_status, 8'(bits));
   endtask

   task automatic wait_rx_valid();
      ps2_status_t st;
      read_status(st);
      while (!st.rx_valid)
         read_status(st);
   endtask

   task automatic wait_tx_idle();
      ps2_status_t st;
      read_status(st);
      while (st.tx_busy)
         read_status(st);
   endtask

   // Device to host, data changes while the clock is high
   task automatic send_frame(input logic [7:0] b, input logic bad);
      logic [10:0] bits;
      bits = {1'b1, (~^b) ^ bad, b, 1'b0};
      for (int i = 0; i < 11; i++)
      begin
         dev_d_low <= ~bits[i];
         wait_cycles(half_bit / 2);
         dev_c_low <= 1'b1;
         wait_cycles(half_bit);
         dev_c_low <= 1'b0;
         wait_cycles(half_bit / 2);
      end
      dev_d_low <= 1'b0;
      wait_cycles(half_bit);
   endtask

   task automatic dev_clock(output logic sample);
      dev_c_low <= 1'b1;
      wait_cycles(half_bit);
      sample = ps2d;   // Just before the rising edge
      dev_c_low <= 1'b0;
      wait_cycles(half_bit);
   endtask

   task automatic recv_frame(input logic do_ack, output logic [7:0] got);
      logic [10:0] bits;
      logic        unused;
      while (ps2c !== 1'b0)
         @(posedge clk);
      // Request to send: clock released with data held low
      while (!(ps2c === 1'b1 && ps2d === 1'b0))
         @(posedge clk);
      wait_cycles(half_bit / 2);
      for (int i = 0; i < 11; i++)
         dev_clock(bits[i]);
      check("tx start bit", bits[0], 0);
      check("tx odd parity", ^bits[9:1], 1);
      check("tx stop bit", bits[10], 1);
      got = bits[8:1];
      dev_d_low <= do_ack;
      wait_cycles(10);
      dev_clock(unused);
      dev_d_low <= 1'b0;
   endtask

   task automatic add_entry(input kind_e kind, input logic bad, input logic do_ack);
      entry_t e;
      e.kind = kind;
      e.data = 8'($random(seed));
      e.bad  = bad;
      e.ack  = do_ack;
      table_q.push_back(e);
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %0d errors", test_no, name, n_errors - group_base);
      test_no++;
      group_base = n_errors;
   endtask

   task automatic run_entry(input entry_t e);
      ps2_status_t st;
      ps2_status_t clr;
      logic [7:0]  d;
      logic [7:0]  got;
      clr = '0;
      case (e.kind)
         k_rx:
         begin
            send_frame(e.data, e.bad);
            wait_rx_valid();
            wb_read(reg_data, d);
            check("dat_r", d, e.data);
            read_status(st);
            check("status.parity_err", st.parity_err, e.bad);
            check("status.rx_valid", st.rx_valid, 0);
            clr.parity_err = 1'b1;
            clear_sticky(clr);
         end
         k_fill:
         begin
            send_frame(e.data, 1'b0);
            fill_q.push_back(e.data);
         end
         k_tx:
         begin
            wb_write(reg_data, e.data);
            read_status(st);
            check("status.tx_busy", st.tx_busy, 1);   // Still in the inhibit phase
            recv_frame(e.ack, got);
            check("tx byte", got, e.data);
            wait_tx_idle();
            read_status(st);
            check("status.tx_noack", st.tx_noack, !e.ack);
            check("status.rx_valid", st.rx_valid, 0);   // Own frame not received
            clr.tx_noack = 1'b1;
            clear_sticky(clr);
         end
         default:
         begin
            wb_write(reg_ctrl, 8'h00);
            send_frame(e.data, e.bad);
            read_status(st);
            check("status.rx_valid", st.rx_valid, 0);
            wb_read(reg_data, d);
            check("dat_r", d, 0);
         end
      endcase
   endtask

   task automatic finish_group(input kind_e kind);
      ps2_status_t st;
      ps2_status_t exp_st;
      ps2_status_t clr;
      logic [7:0]  d;
      string       name;
      if (kind == k_fill)
      begin
         exp_st           = '0;
         exp_st.rx_valid  = 1'b1;
         exp_st.fifo_full = 1'b1;
         exp_st.overflow  = 1'b1;
         read_status(st);
         check("status", 32'(st), 32'(exp_st));
         for (int i = 0; i < `PS2_FIFO_DEPTH; i++)
         begin
            wb_read(reg_data, d);
            check("dat_r", d, fill_q[i]);
         end
         read_status(st);
         check("status.rx_valid", st.rx_valid, 0);   // Last frame was dropped
         clr          = '0;
         clr.overflow = 1'b1;
         clear_sticky(clr);
         read_status(st);
         check("status", 32'(st), 0);
      end
      case (kind)
         k_rx:    name = "receive and parity";
         k_fill:  name = "fifo overflow";
         k_tx:    name = "host transmit";
         default: name = "receiver disabled";
      endcase
      end_test(name);
   endtask

   initial
   begin
      ps2_status_t st;
      logic [7:0]  d;
      reset      = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      dev_c_low  = 1'b0;
      dev_d_low  = 1'b0;
      seed       = 32'h5279e8c8;
      cycles     = 0;
      n_checks   = 0;
      n_errors   = 0;
      group_base = 0;
      test_no    = 1;

      for (int i = 0; i < 6; i++)
         add_entry(k_rx, (i == 1 || i == 2 || i == 4), 1'b1);
      for (int i = 0; i < `PS2_FIFO_DEPTH + 1; i++)
         add_entry(k_fill, 1'b0, 1'b1);
      add_entry(k_tx, 1'b0, 1'b1);
      add_entry(k_tx, 1'b0, 1'b1);
      add_entry(k_tx, 1'b0, 1'b0);
      add_entry(k_off, 1'b0, 1'b1);
      add_entry(k_off, 1'b1, 1'b1);
      limit = 2 * table_q.size() * (int'(`PS2_INHIBIT_CYCLES) + 12 * 2 * half_bit);

      repeat (16) @(posedge clk);
      reset <= 1'b0;

      read_status(st);
      check("status", 32'(st), 0);
      wb_read(reg_data, d);
      check("dat_r", d, 0);
      wb_read(reg_ctrl, d);
      check("ctrl", d, 0);
      end_test("reset state");

      wb_write(reg_ctrl, 8'h01);
      wb_read(reg_ctrl, d);
      check("ctrl", d, 8'h01);
      for (int i = 0; i < table_q.size(); i++)
      begin
         run_entry(table_q[i]);
         if (i == table_q.size() - 1 || table_q[i+1].kind != table_q[i].kind)
            finish_group(table_q[i].kind);
      end

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end
endmodule

// ==== verilog.f ====
+incdir+design
design/ps2_pkg.sv
design/ps2_clk_filter.sv
design/ps2_rx.sv
design/ps2_tx.sv
design/ps2_rx_fifo.sv
design/ps2_wb_regs.sv
design/ps2_host.sv
sim/ps2_host_tb.sv

// ==== Makefile ====
TOP = ps2_host_tb

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean
